// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary -j 0
TOP      = bscTop_tb
FILELIST = bscTop.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== bscTop.f ====
+incdir+source
source/bscBusPkg.sv
source/bscRegPkg.sv
source/bscControl.sv
source/bscRegisters.sv
source/bscRefreshTimer.sv
source/bscDataPath.sv
source/bscTop.sv
tests/bscTop_tb.sv

// ==== source/bscBusPkg.sv ====
package bscBusPkg;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wrData;
		logic [3:0]  byteEn; // Bit 3 is the lowest byte address
		logic        write;
		logic        req;
	} cpuReqT;

	typedef struct packed {
		logic [31:0] rdData;
		logic        busy;
	} cpuRspT;

	typedef struct packed {
		logic [26:0] addr;
		logic [31:0] dataOut;
		logic [3:0]  csN;
		logic        bsN;
		logic        rdN;
		logic        rdWrN;
		logic [3:0]  weN;
		logic        rfs;
	} extBusT;

	typedef struct packed {
		logic [1:0] size; // 1 byte, 2 word, 3 long
		logic [1:0] waitCode;
		logic [1:0] longWait;
	} areaCfgT;

	typedef struct packed {
		logic [3:0] csN;
		logic       bsN;
		logic       rdN;
		logic       rdWrN;
		logic       weEn;
		logic       rfs;
	} strobeT;

	typedef enum logic [2:0] {T0, T1, TW, T2, TRFS1, TRFS2} busStateT;

endpackage

// ==== source/bscControl.sv ====
`timescale 1ns/1ps
`include "bsc_macros.svh"

module bscControl import bscBusPkg::*; (
	input  logic    CLK,
	input  logic    RST_N,
	input  cpuReqT  cpuReq,
	input  logic    extReq,
	input  areaCfgT areaCfg,
	input  logic    rfsReq,
	input  logic    WAIT_N,
	input  logic    lastStep,
	output logic    load,
	output logic    advance,
	output logic    latch,
	output logic    rfsAck,
	output logic    busy,
	output strobeT  strobes
);

	busStateT state;
	logic [2:0] waitCnt;
	logic [2:0] waitLen;
	logic [1:0] rfsCnt;
	logic done; // Completion cycle of an access
	logic inCycle;

	always_comb begin
		case (areaCfg.waitCode)
			2'd0: waitLen = 3'd0;
			2'd3: waitLen = {1'b0, areaCfg.longWait} + 3'd3;
			default: waitLen = {1'b0, areaCfg.waitCode};
		endcase
	end

	assign load = (state == T0) & ~rfsReq & extReq & ~done;
	assign advance = (state == T2) & ~lastStep;
	assign latch = (state == T2) & ~cpuReq.write;
	assign rfsAck = (state == TRFS1);
	assign busy = extReq & ~done;

	assign inCycle = (state == T1) | (state == TW) | (state == T2);
	assign strobes.csN = inCycle ? ~(4'b0001 << cpuReq.addr[26:25]) : 4'b1111;
	assign strobes.bsN = (state != T1);
	assign strobes.rdN = ~(inCycle & ~cpuReq.write);
	assign strobes.rdWrN = ~(inCycle & cpuReq.write);
	assign strobes.weEn = inCycle & cpuReq.write;
	assign strobes.rfs = (state == TRFS1);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= T0;
			waitCnt <= '0;
			rfsCnt <= '0;
			done <= 1'b0;
		end else begin
			done <= (state == T2) & lastStep;
			case (state)
				T0: begin
					if (rfsReq) begin // Refresh wins over a CPU access
						rfsCnt <= `BSC_RFS_CYCLES - 2'd1;
						state <= TRFS1;
					end else if (load) begin
						state <= T1;
					end
				end
				T1: begin
					if (waitLen == 3'd0) begin
						state <= T2;
					end else begin
						waitCnt <= waitLen - 3'd1;
						state <= TW;
					end
				end
				TW: begin
					if (waitCnt != 3'd0) begin
						waitCnt <= waitCnt - 3'd1;
					end else if (WAIT_N) begin
						state <= T2;
					end
				end
				T2: state <= lastStep ? T0 : T1; // Next sizing step follows directly
				TRFS1: begin
					if (rfsCnt == 2'd0) begin
						state <= TRFS2;
					end else begin
						rfsCnt <= rfsCnt - 2'd1;
					end
				end
				TRFS2: state <= T0;
				default: state <= T0;
			endcase
		end
	end

endmodule

// ==== source/bscDataPath.sv ====
`timescale 1ns/1ps

module bscDataPath import bscBusPkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  cpuReqT      cpuReq,
	input  areaCfgT     areaCfg,
	input  logic        load,
	input  logic        advance,
	input  logic        latch,
	input  logic [31:0] DI,
	output logic [26:0] addr,
	output logic [31:0] dataOut,
	output logic [3:0]  weN,
	output logic        lastStep,
	output logic [31:0] readData
);

	logic [31:0] wrData;
	logic [3:0] byteEn;
	logic write;
	logic [1:0] offset; // First byte of the step inside the long word
	logic [2:0] stepBytes;
	logic [2:0] stepEnd;
	logic [5:0] shiftAmt;
	logic [31:0] widthMask;
	logic [3:0] laneMask;

	always_comb begin
		case (areaCfg.size)
			2'd1: begin
				offset = addr[1:0];
				stepBytes = 3'd1;
				widthMask = 32'h0000_00FF;
				laneMask = 4'b0001;
			end
			2'd2: begin
				offset = {addr[1], 1'b0};
				stepBytes = 3'd2;
				widthMask = 32'h0000_FFFF;
				laneMask = 4'b0011;
			end
			default: begin
				offset = 2'd0;
				stepBytes = 3'd4;
				widthMask = '1;
				laneMask = 4'b1111;
			end
		endcase
	end

	// Big endian slice sits 4 - stepEnd bytes above bit 0
	assign stepEnd = {1'b0, offset} + stepBytes;
	assign shiftAmt = {3'd4 - stepEnd, 3'b000};
	assign dataOut = (wrData >> shiftAmt) & widthMask;
	assign weN = ~({4{write}} & (byteEn >> (3'd4 - stepEnd)) & laneMask);
	assign lastStep = ~|(byteEn & (4'b1111 >> stepEnd)); // No enabled byte left

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			byteEn <= '0;
			write <= 1'b0;
		end else if (load) begin
			byteEn <= cpuReq.byteEn;
			write <= cpuReq.write;
		end
	end

	always_ff @(posedge CLK) begin
		if (load) begin
			addr <= cpuReq.addr[26:0];
			wrData <= cpuReq.wrData;
		end else if (advance) begin
			addr <= addr + 27'(stepBytes);
		end
		if (latch) begin
			readData <= (readData & ~(widthMask << shiftAmt)) | ((DI & widthMask) << shiftAmt);
		end
	end

endmodule

// ==== source/bscRefreshTimer.sv ====
`timescale 1ns/1ps
`include "bsc_macros.svh"

module bscRefreshTimer import bscRegPkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  rtcsrT      rtcsr,
	input  rtcorT      rtcor,
	input  logic       rfshEn,
	input  logic       rtcntWr,
	input  logic [7:0] wrData,
	input  logic       rfsAck,
	output rtcntT      rtcnt,
	output logic       rfsReq
);

	logic [11:0] prescale;
	logic tick;
	rtcntT rtcntNext;

	always_comb begin
		case (rtcsr.clockSel)
			3'd1: tick = &prescale[1:0]; // Divide by 4
			3'd2: tick = &prescale[3:0];
			3'd3: tick = &prescale[5:0];
			3'd4: tick = &prescale[7:0];
			3'd5: tick = &prescale[9:0];
			3'd6: tick = &prescale[10:0];
			3'd7: tick = &prescale; // Divide by 4096
			default: tick = 1'b0;
		endcase
	end

	assign rtcntNext = rtcnt + 8'd1;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			prescale <= '0;
			rtcnt <= rtcntT'(`BSC_RTCNT_INIT);
			rfsReq <= 1'b0;
		end else begin
			prescale <= prescale + 12'd1;
			if (rfsAck) rfsReq <= 1'b0;
			if (rtcntWr) begin
				rtcnt <= rtcntT'({8'h00, wrData} & `BSC_RTCNT_WMASK);
			end else if (tick) begin
				if (rtcntNext == rtcor) begin // Compare match
					rtcnt <= '0;
					if (rfshEn) rfsReq <= 1'b1;
				end else begin
					rtcnt <= rtcntNext;
				end
			end
		end
	end

endmodule

// ==== source/bscRegPkg.sv ====
package bscRegPkg;

	typedef struct packed {
		logic [5:0] rsvdHi;
		logic [1:0] longWaitHigh; // Areas 2 and 3
		logic [1:0] longWait1;
		logic [1:0] longWait0;
		logic [3:0] rsvdLo;
	} bcr1T;

	typedef struct packed {
		logic [7:0] rsvdHi;
		logic [1:0] size3;
		logic [1:0] size2;
		logic [1:0] size1;
		logic [1:0] rsvdLo;
	} bcr2T;

	typedef struct packed {
		logic [7:0] rsvdHi; // Idle cycle fields unused
		logic [1:0] waitCode3;
		logic [1:0] waitCode2;
		logic [1:0] waitCode1;
		logic [1:0] waitCode0;
	} wcrT;

	typedef struct packed {
		logic [12:0] rsvdHi;
		logic        refreshEn;
		logic [1:0]  rsvdLo;
	} mcrT;

	typedef struct packed {
		logic [9:0] rsvdHi;
		logic [2:0] clockSel; // 0 stops the timer
		logic [2:0] rsvdLo;
	} rtcsrT;

	typedef logic [7:0] rtcntT;
	typedef logic [7:0] rtcorT;

endpackage

// ==== source/bscRegisters.sv ====
`timescale 1ns/1ps
`include "bsc_macros.svh"

module bscRegisters import bscBusPkg::*, bscRegPkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  cpuReqT      cpuReq,
	input  logic [1:0]  mode,
	output logic [31:0] regData,
	output logic        regSel,
	output logic        extReq,
	output areaCfgT     areaCfg,
	output rtcsrT       rtcsr,
	output rtcorT       rtcor,
	output logic        rfshEn,
	output logic        rtcntWr,
	input  rtcntT       rtcntIn
);

	bcr1T bcr1;
	bcr2T bcr2;
	wcrT wcr;
	mcrT mcr;
	logic [4:0] ofs;
	logic wrEn;
	logic [15:0] wrVal;
	logic [15:0] rdVal;

	assign regSel = cpuReq.addr >= `BSC_REG_BASE;
	assign extReq = cpuReq.req & ~regSel;
	assign ofs = {cpuReq.addr[4:2], 2'b00};
	assign wrVal = cpuReq.wrData[15:0];
	assign wrEn = cpuReq.req & regSel & cpuReq.write & (cpuReq.wrData[31:16] == `BSC_WRITE_KEY);
	assign rtcntWr = wrEn & (ofs == `BSC_OFS_RTCNT); // Counter itself lives in the timer
	assign rfshEn = mcr.refreshEn;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			bcr1 <= `BSC_BCR1_INIT;
			bcr2 <= `BSC_BCR2_INIT;
			wcr <= `BSC_WCR_INIT;
			mcr <= `BSC_MCR_INIT;
			rtcsr <= `BSC_RTCSR_INIT;
			rtcor <= rtcorT'(`BSC_RTCOR_INIT);
		end else if (wrEn) begin
			case (ofs)
				`BSC_OFS_BCR1: bcr1 <= wrVal & `BSC_BCR1_WMASK;
				`BSC_OFS_BCR2: bcr2 <= wrVal & `BSC_BCR2_WMASK;
				`BSC_OFS_WCR: wcr <= wrVal & `BSC_WCR_WMASK;
				`BSC_OFS_MCR: mcr <= wrVal & `BSC_MCR_WMASK;
				`BSC_OFS_RTCSR: rtcsr <= wrVal & `BSC_RTCSR_WMASK;
				`BSC_OFS_RTCOR: rtcor <= rtcorT'(wrVal & `BSC_RTCOR_WMASK);
				default: ;
			endcase
		end
	end

	always_comb begin
		case (ofs)
			`BSC_OFS_BCR1: rdVal = bcr1 & `BSC_BCR1_RMASK;
			`BSC_OFS_BCR2: rdVal = bcr2 & `BSC_BCR2_RMASK;
			`BSC_OFS_WCR: rdVal = wcr & `BSC_WCR_RMASK;
			`BSC_OFS_MCR: rdVal = mcr & `BSC_MCR_RMASK;
			`BSC_OFS_RTCSR: rdVal = rtcsr & `BSC_RTCSR_RMASK;
			`BSC_OFS_RTCNT: rdVal = {8'h00, rtcntIn} & `BSC_RTCNT_RMASK;
			`BSC_OFS_RTCOR: rdVal = {8'h00, rtcor} & `BSC_RTCOR_RMASK;
			default: rdVal = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (cpuReq.req & regSel & ~cpuReq.write) begin
			regData <= {16'h0000, rdVal};
		end
	end

	// Area 0 width comes from the mode pins
	always_comb begin
		case (cpuReq.addr[26:25])
			2'd0: areaCfg = '{mode + 2'd1, wcr.waitCode0, bcr1.longWait0};
			2'd1: areaCfg = '{bcr2.size1, wcr.waitCode1, bcr1.longWait1};
			2'd2: areaCfg = '{bcr2.size2, wcr.waitCode2, bcr1.longWaitHigh};
			default: areaCfg = '{bcr2.size3, wcr.waitCode3, bcr1.longWaitHigh};
		endcase
	end

endmodule

// ==== source/bscTop.sv ====
`timescale 1ns/1ps

module bscTop import bscBusPkg::*, bscRegPkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  cpuReqT      cpuReq,
	output cpuRspT      cpuRsp,
	input  logic [1:0]  mode,
	input  logic [31:0] DI,
	input  logic        WAIT_N,
	output extBusT      extBus
);

	areaCfgT areaCfg;
	rtcsrT rtcsr;
	rtcorT rtcor;
	rtcntT rtcnt;
	strobeT strobes;
	logic [31:0] regData;
	logic [31:0] readData;
	logic [31:0] dataOut;
	logic [26:0] addr;
	logic [3:0] weN;
	logic regSel, extReq, busy;
	logic load, advance, latch, lastStep;
	logic rfsReq, rfsAck, rfshEn, rtcntWr;

	bscControl ctrl (.*);
	bscRegisters regs (.*, .rtcntIn(rtcnt));
	bscRefreshTimer timer (.*, .wrData(cpuReq.wrData[7:0]));
	bscDataPath dataPath (.*);

	assign extBus.addr = addr;
	assign extBus.dataOut = dataOut;
	assign extBus.csN = strobes.csN;
	assign extBus.bsN = strobes.bsN;
	assign extBus.rdN = strobes.rdN;
	assign extBus.rdWrN = strobes.rdWrN;
	assign extBus.weN = weN | {4{~strobes.weEn}}; // Lanes only from T1 through T2
	assign extBus.rfs = strobes.rfs;

	assign cpuRsp.rdData = regSel ? regData : readData;
	assign cpuRsp.busy = busy;

endmodule

// ==== source/bsc_macros.svh ====
`ifndef BSC_MACROS_SVH
`define BSC_MACROS_SVH

`define BSC_REG_BASE     32'hFFFF_FFE0
`define BSC_WRITE_KEY    16'hA55A

`define BSC_OFS_BCR1     5'h00
`define BSC_OFS_BCR2     5'h04
`define BSC_OFS_WCR      5'h08
`define BSC_OFS_MCR      5'h0C
`define BSC_OFS_RTCSR    5'h10
`define BSC_OFS_RTCNT    5'h14
`define BSC_OFS_RTCOR    5'h18

`define BSC_BCR1_WMASK   16'h03F0
`define BSC_BCR2_WMASK   16'h00FC
`define BSC_WCR_WMASK    16'h00FF
`define BSC_MCR_WMASK    16'h0004
`define BSC_RTCSR_WMASK  16'h0038
`define BSC_RTCNT_WMASK  16'h00FF
`define BSC_RTCOR_WMASK  16'h00FF

`define BSC_BCR1_RMASK   16'h03F0
`define BSC_BCR2_RMASK   16'h00FC
`define BSC_WCR_RMASK    16'h00FF
`define BSC_MCR_RMASK    16'h0004
`define BSC_RTCSR_RMASK  16'h00F8
`define BSC_RTCNT_RMASK  16'h00FF
`define BSC_RTCOR_RMASK  16'h00FF

`define BSC_BCR1_INIT    16'h03F0
`define BSC_BCR2_INIT    16'h00FC
`define BSC_WCR_INIT     16'h00FF
`define BSC_MCR_INIT     16'h0000
`define BSC_RTCSR_INIT   16'h0000
`define BSC_RTCNT_INIT   16'h0000
`define BSC_RTCOR_INIT   16'h0000

`define BSC_RFS_CYCLES   2'd2

`endif

// ==== tests/bscTop_tb.sv ====
`timescale 1ns/1ps
`include "bsc_macros.svh"

module bscTop_tb import bscBusPkg::*; ();

	logic CLK;
	logic RST_N;
	cpuReqT cpuReq;
	cpuRspT cpuRsp;
	logic [1:0] mode;
	logic [31:0] DI = '0;
	logic WAIT_N = 1'b1;
	extBusT extBus;

	logic [31:0] trace [0:1023];
	logic [7:0] mem [int]; // Byte addressed external memory
	logic [31:0] opAddr, opData;
	logic [3:0] opBe;
	logic opCheckWrites = 1'b0;
	logic [31:0] nextDI = '0;
	logic nextWaitN = 1'b1;
	int stretchLow = 0;
	int waitLow = 0;
	int busStarts = 0;
	int csLowCycles = 0;
	int cycles = 0;
	int cycleLimit = 0;
	string testName;

	bscTop dut_i (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) reportFailure($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
	endtask

	function automatic int areaBytes(input logic [1:0] area);
		logic [1:0] code;
		code = (area == 2'd0) ? mode + 2'd1 : ((area == 2'd1) ? 2'd2 : 2'd3);
		return (code == 2'd3) ? 4 : int'(code);
	endfunction

	function automatic logic [7:0] patternByte(input logic [26:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'd0, a[26:24]};
	endfunction

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		DI <= nextDI;
		WAIT_N <= nextWaitN;
		if (cycleLimit != 0 && cycles >= cycleLimit)
			reportFailure($sformatf("Timeout: the run took more than %0d cycles", cycleLimit));
	end

	// Memory model answering the strobes on big endian lanes
	always @(negedge CLK) begin : memModel
		int w;
		int offInt;
		logic [26:0] base;
		logic [26:0] a;
		logic [31:0] word;
		if (RST_N && extBus.csN != 4'hF) begin
			w = areaBytes(extBus.addr[26:25]);
			base = extBus.addr & ~27'(w - 1);
			word = '0;
			csLowCycles++;
			checkValue({testName, " chip select"}, 32'd1,
				32'(!extBus.csN[opAddr[26:25]] && $countones(extBus.csN) == 3));
			checkValue({testName, " RD_N"}, {31'd0, opCheckWrites}, {31'd0, extBus.rdN});
			checkValue({testName, " RD_WR_N"}, {31'd0, ~opCheckWrites}, {31'd0, extBus.rdWrN});
			if (!extBus.bsN) busStarts++;
			if (!extBus.bsN && stretchLow > 0) waitLow = stretchLow;
			for (int j = 0; j < w; j++) begin
				a = base + 27'(w - 1 - j);
				if (!extBus.weN[j]) begin
					mem[int'(a)] = extBus.dataOut[8*j +: 8];
					offInt = int'(a - opAddr[26:0]);
					if (opCheckWrites) begin
						checkValue({testName, " lane enable"}, 32'd1,
							32'((offInt >= 0 && offInt < 4) ? opBe[2'(3 - offInt)] : 1'b0));
						checkValue({testName, " byte"}, {24'd0, 8'(opData >> (8 * (3 - offInt)))},
							{24'd0, extBus.dataOut[8*j +: 8]});
					end
				end
				word[8*j +: 8] = mem.exists(int'(a)) ? mem[int'(a)] : patternByte(a);
			end
			nextDI = word;
		end
		nextWaitN = (waitLow == 0); // WAIT_N low from the cycle after T1
		if (waitLow > 0) waitLow--;
	end

	task automatic accessRegister(input logic isWrite, output logic [31:0] data);
		@(posedge CLK);
		cpuReq <= '{opAddr, opData, opBe, isWrite, 1'b1};
		@(posedge CLK);
		cpuReq.req <= 1'b0;
		@(negedge CLK);
		data = cpuRsp.rdData;
	endtask

	task automatic accessExternal(input logic isWrite, output logic [31:0] data);
		@(posedge CLK);
		cpuReq <= '{opAddr, opData, opBe, isWrite, 1'b1};
		do @(negedge CLK); while (cpuRsp.busy);
		data = cpuRsp.rdData;
		@(posedge CLK);
		cpuReq.req <= 1'b0;
	endtask

	task automatic checkRefresh(input logic [31:0] limit);
		int waited;
		int high;
		waited = 0;
		while (!extBus.rfs && waited <= int'(limit)) begin
			@(negedge CLK);
			waited++;
		end
		checkValue({testName, " refresh start"}, 32'd1, 32'(waited <= int'(limit)));
		high = 0;
		while (extBus.rfs) begin
			checkValue({testName, " chip selects"}, 32'hF, {28'd0, extBus.csN});
			high++;
			@(negedge CLK);
		end
		checkValue({testName, " refresh length"}, 32'(`BSC_RFS_CYCLES), 32'(high));
	endtask

	initial begin
		int numOps;
		int startBs;
		int startCs;
		logic [31:0] op, stretch, expected, got;
		RST_N <= 1'b0;
		cpuReq <= '0;
		mode = 2'd0; // Area 0 is 8 bits wide
		for (int i = 0; i < 1024; i++) trace[i] = '1;
		$readmemh("tests/bscTop_trace.txt", trace);
		numOps = 0;
		while (numOps < 170 && trace[6 * numOps] != '1) numOps++;
		cycleLimit = numOps * 200 + 5000;
		repeat (16) @(posedge CLK);
		RST_N <= 1'b1;
		for (int i = 0; i < numOps; i++) begin
			op = trace[6 * i];
			opAddr = trace[6 * i + 1];
			opData = trace[6 * i + 2];
			opBe = trace[6 * i + 3][3:0];
			stretch = trace[6 * i + 4];
			expected = trace[6 * i + 5];
			testName = $sformatf("op %0d (type %0d, address %h)", i, op, opAddr);
			case (op)
				0, 1, 6: begin
					accessRegister(op == 0, got);
					if (op == 1) checkValue(testName, expected, got);
					if (op == 6) checkValue(testName, 32'd1, 32'(got < expected));
				end
				2, 3, 4: begin
					startBs = busStarts;
					startCs = csLowCycles;
					opCheckWrites = (op == 2);
					stretchLow = int'(stretch);
					accessExternal(op == 2, got);
					opCheckWrites = 1'b0;
					stretchLow = 0;
					if (op == 2) checkValue(testName, expected, 32'(busStarts - startBs));
					if (op == 3) checkValue(testName, expected, got);
					if (op == 4) checkValue(testName, expected, 32'(csLowCycles - startCs));
				end
				5: checkRefresh(expected);
				default: reportFailure($sformatf("Unknown operation %0d in trace entry %0d", op, i));
			endcase
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== tests/bscTop_trace.txt ====
// Columns: op address data byteEnable waitStretch expected
// op 0 reg write, 1 reg read, 2 ext write (bus cycles), 3 ext read, 4 CS low cycles, 5 refresh (max cycles), 6 reg read below
0 FFFFFFE4 A55A00F8 0 0 00000000
1 FFFFFFE4 00000000 0 0 000000F8
0 FFFFFFE8 A55A1234 0 0 00000000
1 FFFFFFE8 00000000 0 0 00000034
0 FFFFFFE8 0000FFFF 0 0 00000000
1 FFFFFFE8 00000000 0 0 00000034
0 FFFFFFF0 A55A00FF 0 0 00000000
1 FFFFFFF0 00000000 0 0 00000038
0 FFFFFFE0 A55A0100 0 0 00000000
1 FFFFFFE0 00000000 0 0 00000100
2 00000100 11223344 F 0 00000004
3 00000100 00000000 F 0 11223344
2 00000104 AABBCCDD 6 0 00000003
3 00000104 00000000 F 0 05BBCC06
2 02000200 CAFEF00D F 0 00000002
3 02000200 00000000 F 0 CAFEF00D
2 04000300 DEADBEEF F 0 00000001
3 04000300 00000000 F 0 DEADBEEF
3 04000400 00000000 F 0 00010203
4 04000300 00000000 F 0 00000006
0 FFFFFFE8 A55A0014 0 0 00000000
4 04000300 00000000 F 0 00000003
4 04000300 00000000 F 3 00000006
0 FFFFFFE8 A55A0024 0 0 00000000
4 04000300 00000000 F 0 00000004
0 FFFFFFE8 A55A0004 0 0 00000000
4 04000300 00000000 F 0 00000002
0 FFFFFFF8 A55A0010 0 0 00000000
1 FFFFFFF8 00000000 0 0 00000010
0 FFFFFFF4 A55A0000 0 0 00000000
0 FFFFFFF0 A55A0008 0 0 00000000
1 FFFFFFF0 00000000 0 0 00000008
0 FFFFFFEC A55A0004 0 0 00000000
1 FFFFFFEC 00000000 0 0 00000004
5 00000000 00000000 0 0 00000058
6 FFFFFFF4 00000000 0 0 00000010
